// File: sim.f
fsync_pkg.sv
fsync_node.sv
fsync_root.sv
fsync_regs.sv
fsync_top.sv
fsync_sva.sv
tb_fsync.sv

// File: Makefile
# Verilator build and run of the barrier tree testbench

VERILATOR ?= verilator
TOP       ?= tb_fsync
FLIST     ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test completed successfully

SRCS := $(filter %.sv %.v,$(shell cat $(FLIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# the log decides, not the exit code of the simulation
run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_fsync.sv
// testbench for the barrier tree, runs random tile rounds and wishbone accesses against a model
`timescale 1ns/1ps

module tb_fsync
  import fsync_pkg::*;
();

  localparam int LEVELS    = 3;
  localparam int N_TILES   = 2**LEVELS;
  // cycle budgets for one round and one bus access
  localparam int ROUND_TMO = 200;
  localparam int WB_TMO    = 20;

  logic                          clk;
  logic                          rst_i;
  logic [N_TILES-1:0]            sync_req_i;
  logic [N_TILES-1:0][LVL_W-1:0] sync_lvl_i;
  logic [N_TILES-1:0]            sync_ack_o;
  logic [N_TILES-1:0]            sync_err_o;
  logic                          wb_cyc_i;
  logic                          wb_stb_i;
  logic                          wb_we_i;
  logic [WB_ADDR_W-1:0]          wb_adr_i;
  logic [WB_DATA_W-1:0]          wb_dat_i;
  logic [WB_DATA_W-1:0]          wb_dat_o;
  logic                          wb_ack_o;

  logic [15:0]      lfsr_q;
  // level per tile for the next round
  logic [LVL_W-1:0] tile_lvl [N_TILES];
  // tiles already placed in a barrier block
  logic [N_TILES-1:0] taken;
  // model copy of the enable bit and the barrier count
  logic             model_en;
  logic [CNT_W-1:0] model_cnt;
  int               errors;
  int               timeouts;

  fsync_top #(
    .LEVELS     ( LEVELS     )
  ) dut_i (
    .clk        ( clk        ),
    .rst_i      ( rst_i      ),
    .sync_req_i ( sync_req_i ),
    .sync_lvl_i ( sync_lvl_i ),
    .sync_ack_o ( sync_ack_o ),
    .sync_err_o ( sync_err_o ),
    .wb_cyc_i   ( wb_cyc_i   ),
    .wb_stb_i   ( wb_stb_i   ),
    .wb_we_i    ( wb_we_i    ),
    .wb_adr_i   ( wb_adr_i   ),
    .wb_dat_i   ( wb_dat_i   ),
    .wb_dat_o   ( wb_dat_o   ),
    .wb_ack_o   ( wb_ack_o   )
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("Fail %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input logic [WB_DATA_W-1:0] got,
                            input logic [WB_DATA_W-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic rand_bit();
    logic fb;
    fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(rand_bit());
    end
    return v;
  endfunction

  // top-down split of the free tiles, level 1 blocks always close
  task automatic fill_partition();
    int sz;
    bit free;
    for (int q = LEVELS; q >= 1; q--) begin
      sz = 1 << q;
      for (int b = 0; b < N_TILES; b += sz) begin
        free = 1'b1;
        for (int i = b; i < b + sz; i++) begin
          if (taken[i]) begin
            free = 1'b0;
          end
        end
        if (free && (q == 1 || rand_bit())) begin
          for (int i = b; i < b + sz; i++) begin
            tile_lvl[i] = LVL_W'(q);
            taken[i]    = 1'b1;
          end
        end
      end
    end
  endtask

  // one node gets halves with two different levels above it
  task automatic make_mismatch();
    int   p;
    int   base;
    int   half;
    logic flip;
    p     = 1 + (rand_bits(2) % LEVELS);
    base  = (rand_bits(LEVELS) >> p) << p;
    half  = 1 << (p - 1);
    flip  = rand_bit();
    taken = '0;
    for (int i = 0; i < half; i++) begin
      tile_lvl[base + i]        = LVL_W'(flip ? p + 2 : p + 1);
      tile_lvl[base + half + i] = LVL_W'(flip ? p + 1 : p + 2);
      taken[base + i]           = 1'b1;
      taken[base + half + i]    = 1'b1;
    end
    // rest of the grid closes on its own
    fill_partition();
  endtask

  // ok only if the whole aligned block of 2^L tiles asks for L, with L in the tree
  function automatic logic expect_err(input int t);
    int lv;
    int base;
    lv = int'(tile_lvl[t]);
    if (lv < 1 || lv > LEVELS) begin
      return 1'b1;
    end
    base = (t >> lv) << lv;
    for (int i = base; i < base + (1 << lv); i++) begin
      if (int'(tile_lvl[i]) != lv) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // every tile requests once, each ack drops its request
  task automatic run_round();
    logic [N_TILES-1:0] pend;
    logic [N_TILES-1:0] exp_err;
    int                 n;
    if (timeouts != 0) return;
    for (int t = 0; t < N_TILES; t++) begin
      exp_err[t] = expect_err(t);
    end
    @(posedge clk);
    for (int t = 0; t < N_TILES; t++) begin
      sync_lvl_i[t] <= tile_lvl[t];
    end
    sync_req_i <= '1;
    pend = '1;
    n    = 0;
    while (pend != '0 && n < ROUND_TMO) begin
      @(negedge clk);
      n++;
      for (int t = 0; t < N_TILES; t++) begin
        if (sync_ack_o[t] && !pend[t]) begin
          errors++;
          $display("tile %0d got a second ack at %0t", t, $time);
        end else if (sync_ack_o[t]) begin
          check_bit($sformatf("sync_err_o[%0d]", t), sync_err_o[t], exp_err[t]);
          pend[t] = 1'b0;
          if (model_en && !exp_err[t]) begin
            model_cnt++;
          end
        end
      end
      @(posedge clk);
      sync_req_i <= pend;
    end
    if (pend != '0) begin
      timeouts++;
      $display("round timed out with tiles %b still waiting for an ack", pend);
      return;
    end
    // quiet gap, no stray acks
    repeat (2) begin
      @(negedge clk);
      for (int t = 0; t < N_TILES; t++) begin
        check_bit($sformatf("sync_ack_o[%0d]", t), sync_ack_o[t], 1'b0);
      end
    end
  endtask

  // single classic cycle, ack due one cycle after the strobe
  task automatic wb_access(input logic we, input reg_addr_e adr,
                           input logic [WB_DATA_W-1:0] wdat,
                           output logic [WB_DATA_W-1:0] rdat);
    int   n;
    logic got;
    rdat = '0;
    if (timeouts != 0) return;
    @(posedge clk);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= adr;
    wb_dat_i <= wdat;
    n   = 0;
    got = 1'b0;
    while (!got && n < WB_TMO) begin
      @(negedge clk);
      n++;
      if (wb_ack_o) begin
        got  = 1'b1;
        rdat = wb_dat_o;
      end
    end
    @(posedge clk);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
    if (!got) begin
      timeouts++;
      $display("no wishbone ack for %s", adr.name());
      return;
    end
    // strobe cycle plus the ack cycle
    if (n != 2) begin
      errors++;
      $display("wishbone ack for %s came %0d cycles after the strobe", adr.name(), n - 1);
    end
    @(negedge clk);
    check_bit("wb_ack_o", wb_ack_o, 1'b0);
  endtask

  task automatic wb_write(input reg_addr_e adr, input logic [WB_DATA_W-1:0] wdat);
    logic [WB_DATA_W-1:0] unused;
    wb_access(1'b1, adr, wdat, unused);
  endtask

  task automatic read_expect(input reg_addr_e adr, input logic [WB_DATA_W-1:0] exp);
    logic [WB_DATA_W-1:0] rd;
    wb_access(1'b0, adr, '0, rd);
    if (timeouts != 0) return;
    check_word($sformatf("wb_dat_o(%s)", adr.name()), rd, exp);
  endtask

  task automatic finish_run();
    $display("errors: %0d value, %0d timeout", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  initial begin
    logic [WB_DATA_W-1:0] rd;
    logic [WB_DATA_W-1:0] rd2;
    lfsr_q     = 16'd76;
    errors     = 0;
    timeouts   = 0;
    model_en   = 1'b0;
    model_cnt  = '0;
    taken      = '0;
    rst_i      = 1'b1;
    sync_req_i = '0;
    sync_lvl_i = '0;
    wb_cyc_i   = 1'b0;
    wb_stb_i   = 1'b0;
    wb_we_i    = 1'b0;
    wb_adr_i   = '0;
    wb_dat_i   = '0;
    repeat (16) @(posedge clk);
    rst_i <= 1'b0;

    // all registers clear out of reset
    read_expect(REG_CTRL, '0);
    read_expect(REG_STATUS, '0);
    read_expect(REG_BARRIERS, '0);
    read_expect(REG_CYCLES, '0);
    wb_write(REG_CTRL, 32'h1);
    model_en = 1'b1;
    read_expect(REG_CTRL, 32'h1);

    // random valid partitions
    for (int r = 0; r < 16; r++) begin
      taken = '0;
      fill_partition();
      run_round();
    end
    read_expect(REG_BARRIERS, WB_DATA_W'(model_cnt));

    // sibling disagreement, answered inside the tree
    for (int r = 0; r < 8; r++) begin
      make_mismatch();
      run_round();
    end
    read_expect(REG_BARRIERS, WB_DATA_W'(model_cnt));
    read_expect(REG_STATUS, '0);

    // overflow reaches the root
    for (int t = 0; t < N_TILES; t++) begin
      tile_lvl[t] = LVL_W'(LEVELS + 1);
    end
    run_round();
    read_expect(REG_STATUS, 32'h1);
    wb_write(REG_STATUS, 32'h1);
    read_expect(REG_STATUS, '0);
    read_expect(REG_BARRIERS, WB_DATA_W'(model_cnt));

    // timer runs while enabled
    wb_access(1'b0, REG_CYCLES, '0, rd);
    wb_access(1'b0, REG_CYCLES, '0, rd2);
    check_bit("REG_CYCLES advancing", rd2 != rd, 1'b1);

    // both counters hold while disabled
    wb_write(REG_CTRL, '0);
    model_en = 1'b0;
    wb_access(1'b0, REG_CYCLES, '0, rd);
    taken = '0;
    fill_partition();
    run_round();
    read_expect(REG_BARRIERS, WB_DATA_W'(model_cnt));
    read_expect(REG_CYCLES, rd);

    finish_run();
  end

endmodule

// File: fsync_sva.sv
// handshake and reset assertions bound into every tree node and into the wishbone registers
`timescale 1ns/1ps

module fsync_sva
  import fsync_pkg::*;
(
  input logic        clk,
  input logic        rst_i,
  // two request and ack pairs of the bound block
  input logic [1:0]  req_i,
  input logic [1:0]  ack_i,
  // node state or a constant idle for the registers
  input node_state_e state_i
);

  // acks quiet in the cycle after reset
  ack_after_rst_a: assert property (@(posedge clk) rst_i |=> (ack_i == 2'b00))
    else $error("ack raised right after reset");

  // node only busy while both children keep waiting
  busy_a: assert property (@(posedge clk) disable iff (rst_i)
    (state_i != ST_IDLE) |-> (req_i == 2'b11))
    else $error("node busy without both child requests");

  for (genvar i = 0; i < 2; i++) begin : gen_port
    // request held until answered
    hold_a: assert property (@(posedge clk) disable iff (rst_i)
      (req_i[i] && !ack_i[i]) |=> req_i[i])
      else $error("request %0d dropped before its ack", i);

    // ack only towards a waiting request
    ack_with_req_a: assert property (@(posedge clk) disable iff (rst_i)
      ack_i[i] |-> req_i[i])
      else $error("ack %0d without a request", i);

    // ack is a pulse
    pulse_a: assert property (@(posedge clk) disable iff (rst_i)
      ack_i[i] |=> !ack_i[i])
      else $error("ack %0d longer than one cycle", i);
  end

endmodule

bind fsync_node fsync_sva node_sva_i (
  .clk     ( clk         ),
  .rst_i   ( rst_i       ),
  .req_i   ( child_req_i ),
  .ack_i   ( child_ack_o ),
  .state_i ( state_q     )
);

bind fsync_regs fsync_sva regs_sva_i (
  .clk     ( clk                      ),
  .rst_i   ( rst_i                    ),
  .req_i   ( {2{wb_cyc_i & wb_stb_i}} ),
  .ack_i   ( {2{wb_ack_o}}            ),
  .state_i ( fsync_pkg::ST_IDLE       )
);

// File: fsync_top.sv
// barrier tree top level, builds the node levels, the root and the registers for the tile grid
`timescale 1ns/1ps

module fsync_top
  import fsync_pkg::*;
#(
  // tree depth, 2**LEVELS tiles
  parameter int LEVELS = 3
) (
  input  logic                          clk,
  input  logic                          rst_i,
  // tile ports
  input  logic [2**LEVELS-1:0]            sync_req_i,
  input  logic [2**LEVELS-1:0][LVL_W-1:0] sync_lvl_i,
  output logic [2**LEVELS-1:0]            sync_ack_o,
  output logic [2**LEVELS-1:0]            sync_err_o,
  // wishbone classic slave
  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_we_i,
  input  logic [WB_ADDR_W-1:0]          wb_adr_i,
  input  logic [WB_DATA_W-1:0]          wb_dat_i,
  output logic [WB_DATA_W-1:0]          wb_dat_o,
  output logic                          wb_ack_o
);

  localparam int N_TILES = 2**LEVELS;
  // tile ports, every node parent port, and the root port
  localparam int N_LNK   = 2*N_TILES - 1;

  // links stored level after level, tiles first
  // port level p starts at 2*N_TILES - 2*(N_TILES >> p)
  logic [N_LNK-1:0]            lnk_req;
  logic [N_LNK-1:0][LVL_W-1:0] lnk_lvl;
  logic [N_LNK-1:0]            lnk_ack;
  logic [N_LNK-1:0]            lnk_err;

  logic             enable;
  logic             err_clr;
  logic             err_flag;
  logic [CNT_W-1:0] barriers;
  logic [CNT_W-1:0] cycles;

  assign lnk_req[N_TILES-1:0] = sync_req_i;
  assign lnk_lvl[N_TILES-1:0] = sync_lvl_i;
  assign sync_ack_o           = lnk_ack[N_TILES-1:0];
  assign sync_err_o           = lnk_err[N_TILES-1:0];

  for (genvar l = 1; l <= LEVELS; l++) begin : gen_lvl
    // first child link and first parent link of this level
    localparam int CB = 2*N_TILES - 2*(N_TILES >> (l-1));
    localparam int PB = 2*N_TILES - 2*(N_TILES >> l);
    for (genvar j = 0; j < (N_TILES >> l); j++) begin : gen_node
      fsync_node #(
        .NODE_LVL    ( l )
      ) node_i (
        .clk         ( clk                        ),
        .rst_i       ( rst_i                      ),
        .child_req_i ( lnk_req[CB+2*j+1:CB+2*j]   ),
        .child_lvl_i ( lnk_lvl[CB+2*j+1:CB+2*j]   ),
        .child_ack_o ( lnk_ack[CB+2*j+1:CB+2*j]   ),
        .child_err_o ( lnk_err[CB+2*j+1:CB+2*j]   ),
        .par_req_o   ( lnk_req[PB+j]              ),
        .par_lvl_o   ( lnk_lvl[PB+j]              ),
        .par_ack_i   ( lnk_ack[PB+j]              ),
        .par_err_i   ( lnk_err[PB+j]              )
      );
    end
  end

  // root sits on the last link
  fsync_root #(
    .LEVELS     ( LEVELS )
  ) root_i (
    .clk        ( clk                   ),
    .rst_i      ( rst_i                 ),
    .req_i      ( lnk_req[N_LNK-1]      ),
    .lvl_i      ( lnk_lvl[N_LNK-1]      ),
    .ack_o      ( lnk_ack[N_LNK-1]      ),
    .err_o      ( lnk_err[N_LNK-1]      ),
    .enable_i   ( enable                ),
    .err_clr_i  ( err_clr               ),
    .tile_ack_i ( lnk_ack[N_TILES-1:0]  ),
    .tile_err_i ( lnk_err[N_TILES-1:0]  ),
    .err_flag_o ( err_flag              ),
    .barriers_o ( barriers              ),
    .cycles_o   ( cycles                )
  );

  fsync_regs regs_i (
    .clk        ( clk      ),
    .rst_i      ( rst_i    ),
    .wb_cyc_i   ( wb_cyc_i ),
    .wb_stb_i   ( wb_stb_i ),
    .wb_we_i    ( wb_we_i  ),
    .wb_adr_i   ( wb_adr_i ),
    .wb_dat_i   ( wb_dat_i ),
    .wb_dat_o   ( wb_dat_o ),
    .wb_ack_o   ( wb_ack_o ),
    .enable_o   ( enable   ),
    .err_clr_o  ( err_clr  ),
    .err_flag_i ( err_flag ),
    .barriers_i ( barriers ),
    .cycles_i   ( cycles   )
  );

endmodule

// File: fsync_regs.sv
// wishbone classic slave registers that enable the counters and read back the tree status
`timescale 1ns/1ps

module fsync_regs
  import fsync_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_i,
  // wishbone classic slave
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  logic [WB_ADDR_W-1:0] wb_adr_i,
  input  logic [WB_DATA_W-1:0] wb_dat_i,
  output logic [WB_DATA_W-1:0] wb_dat_o,
  output logic                 wb_ack_o,
  // root side
  output logic                 enable_o,
  output logic                 err_clr_o,
  input  logic                 err_flag_i,
  input  logic [CNT_W-1:0]     barriers_i,
  input  logic [CNT_W-1:0]     cycles_i
);

  reg_addr_e            addr;
  logic                 access;
  logic                 wr;
  logic                 ack_q;
  logic                 en_q;
  logic                 clr_q;
  logic [WB_DATA_W-1:0] rdata;
  logic [WB_DATA_W-1:0] dat_q;

  assign addr = reg_addr_e'(wb_adr_i);

  // new access only while no ack is out
  // keeps every ack a single cycle
  assign access = wb_cyc_i & wb_stb_i & ~ack_q;
  assign wr     = access & wb_we_i;

  // read mux
  always_comb begin
    rdata = '0;
    case (addr)
      REG_CTRL:     rdata[0] = en_q;
      REG_STATUS:   rdata[0] = err_flag_i;
      REG_BARRIERS: rdata = WB_DATA_W'(barriers_i);
      REG_CYCLES:   rdata = WB_DATA_W'(cycles_i);
      default:      rdata = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_q <= 1'b0;
      en_q  <= 1'b0;
      clr_q <= 1'b0;
    end else begin
      ack_q <= access;
      // write 1 to clear, as a one-cycle pulse
      clr_q <= wr & (addr == REG_STATUS) & wb_dat_i[0];
      if (wr && (addr == REG_CTRL)) begin
        en_q <= wb_dat_i[0];
      end
    end
  end

  // read data lands together with the ack
  always_ff @(posedge clk) begin
    if (access) begin
      dat_q <= rdata;
    end
  end

  assign wb_ack_o  = ack_q;
  assign wb_dat_o  = dat_q;
  assign enable_o  = en_q;
  assign err_clr_o = clr_q;

endmodule

// File: fsync_root.sv
// root end of the barrier tree, answers overflow requests and keeps the error flag and counters
`timescale 1ns/1ps

module fsync_root
  import fsync_pkg::*;
#(
  // tree depth below the root
  parameter int LEVELS = 3
) (
  input  logic                  clk,
  input  logic                  rst_i,
  // parent port of the top node
  input  logic                  req_i,
  input  logic [LVL_W-1:0]      lvl_i,
  output logic                  ack_o,
  output logic                  err_o,
  // register block side
  input  logic                  enable_i,
  input  logic                  err_clr_i,
  // tile answers, for the barrier count
  input  logic [2**LEVELS-1:0]  tile_ack_i,
  input  logic [2**LEVELS-1:0]  tile_err_i,
  output logic                  err_flag_o,
  output logic [CNT_W-1:0]      barriers_o,
  output logic [CNT_W-1:0]      cycles_o
);

  localparam int N_TILES = 2**LEVELS;

  logic             ack_q;
  logic             err_q;
  logic             flag_q;
  logic [CNT_W-1:0] bar_q;
  logic [CNT_W-1:0] cyc_q;
  logic [CNT_W-1:0] bar_inc;

  // one-cycle answer, a cycle after the request shows up
  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req_i & ~ack_q;
    end
  end

  // top node closes LEVELS itself, anything arriving here asks for more
  always_ff @(posedge clk) begin
    if (req_i && !ack_q) begin
      err_q <= (lvl_i > LVL_W'(LEVELS));
    end
  end

  assign ack_o = ack_q;
  assign err_o = ack_q & err_q;

  // sticky overflow flag, a new error wins over a clear
  always_ff @(posedge clk) begin
    if (rst_i) begin
      flag_q <= 1'b0;
    end else if (ack_q && err_q) begin
      flag_q <= 1'b1;
    end else if (err_clr_i) begin
      flag_q <= 1'b0;
    end
  end

  // error-free tile acks in this cycle
  always_comb begin
    bar_inc = '0;
    for (int t = 0; t < N_TILES; t++) begin
      bar_inc = bar_inc + CNT_W'(tile_ack_i[t] & ~tile_err_i[t]);
    end
  end

  // both counters frozen while disabled
  always_ff @(posedge clk) begin
    if (rst_i) begin
      bar_q <= '0;
      cyc_q <= '0;
    end else if (enable_i) begin
      bar_q <= bar_q + bar_inc;
      cyc_q <= cyc_q + CNT_W'(1);
    end
  end

  assign err_flag_o = flag_q;
  assign barriers_o = bar_q;
  assign cycles_o   = cyc_q;

endmodule

// File: fsync_node.sv
// one barrier tree node joining two child request ports into one parent port, stacked by fsync_top
`timescale 1ns/1ps

module fsync_node
  import fsync_pkg::*;
#(
  // level at which this node closes a barrier
  parameter int NODE_LVL = 1
) (
  input  logic                  clk,
  input  logic                  rst_i,
  // child side, one port per subtree
  input  logic [1:0]            child_req_i,
  input  logic [1:0][LVL_W-1:0] child_lvl_i,
  output logic [1:0]            child_ack_o,
  output logic [1:0]            child_err_o,
  // parent side
  output logic                  par_req_o,
  output logic [LVL_W-1:0]      par_lvl_o,
  input  logic                  par_ack_i,
  input  logic                  par_err_i
);

  node_state_e           state_q;
  node_state_e           state_d;
  logic [1:0]            req_q;
  logic [1:0][LVL_W-1:0] lvl_q;
  logic                  err_q;
  logic                  both_pend;
  logic                  lvl_same;
  logic                  lvl_own;
  logic                  lvl_above;
  logic                  fwd_ok;
  logic                  par_done;

  // registered view of the children
  // an answered child is dropped at once, it lowers its request a cycle later
  always_ff @(posedge clk) begin
    if (rst_i) begin
      req_q <= '0;
    end else begin
      req_q <= child_req_i & ~child_ack_o;
    end
  end

  // levels are held by the child with its request
  always_ff @(posedge clk) begin
    lvl_q <= child_lvl_i;
  end

  // early child just sits in req_q until the sibling shows up
  assign both_pend = &req_q;
  assign lvl_same  = (lvl_q[0] == lvl_q[1]);
  assign lvl_own   = (lvl_q[0] == LVL_W'(NODE_LVL));
  assign lvl_above = (lvl_q[0] > LVL_W'(NODE_LVL));

  // both agree on a higher level
  assign fwd_ok = lvl_same & lvl_above;

  // parent answer while forwarding
  assign par_done = (state_q == ST_WAIT_PARENT) & par_ack_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (both_pend) begin
          // own level or a disagreement is answered here
          if (fwd_ok) begin
            state_d = ST_WAIT_PARENT;
          end else begin
            state_d = ST_ANSWER;
          end
        end
      end
      ST_WAIT_PARENT: begin
        if (par_ack_i) begin
          state_d = ST_IDLE;
        end
      end
      ST_ANSWER: begin
        state_d = ST_IDLE;
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // local verdict, only read in ST_ANSWER
  // error on unequal levels or a level below this node
  always_ff @(posedge clk) begin
    if ((state_q == ST_IDLE) && both_pend) begin
      err_q <= ~(lvl_same & lvl_own);
    end
  end

  // request upward for the whole wait
  assign par_req_o = (state_q == ST_WAIT_PARENT);
  assign par_lvl_o = lvl_q[0];

  // own answer lasts one cycle
  // parent answer passes straight down in the same cycle
  assign child_ack_o = {2{(state_q == ST_ANSWER) | par_done}};
  assign child_err_o = {2{((state_q == ST_ANSWER) & err_q) | (par_done & par_err_i)}};

endmodule

// File: fsync_pkg.sv
// shared widths, node states and register map of the barrier tree, imported by every design file
package fsync_pkg;

  // barrier level field
  // up to 14 tree levels plus one overflow value
  localparam int LVL_W = 4;

  // wishbone word address and data
  localparam int WB_ADDR_W = 2;
  localparam int WB_DATA_W = 32;

  // barrier counter and cycle timer
  localparam int CNT_W = 32;

  // tree node states
  typedef enum logic [1:0] {
    // collecting both children
    ST_IDLE,
    // level forwarded up, waiting for the answer
    ST_WAIT_PARENT,
    // one cycle of ack towards both children
    ST_ANSWER
  } node_state_e;

  // register word addresses
  typedef enum logic [WB_ADDR_W-1:0] {
    // bit 0 enables both counters
    REG_CTRL     = 2'd0,
    // bit 0 is the sticky overflow error, write 1 to clear
    REG_STATUS   = 2'd1,
    // error-free tile acks, read only
    REG_BARRIERS = 2'd2,
    // free-running cycle timer, read only
    REG_CYCLES   = 2'd3
  } reg_addr_e;

endpackage
